/* Makefile */
# Verilator build and run for the receive lane testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_lane
FILELIST  ?= rx_lane.f
SEED_ARGS ?= +verilator+seed+1
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/rx_lane_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: run lint clean

run: $(SIM_BIN)
	./$(SIM_BIN) $(SEED_ARGS)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* rx_lane.f */
+incdir+verilog
verilog/rx_lane_pkg.sv
verilog/block_if.sv
verilog/rx_gearbox.sv
verilog/block_aligner.sv
verilog/descrambler.sv
verilog/rx_lane.sv
sim/tb_rx_lane.sv

/* sim/tb_rx_lane.sv */
`timescale 1ns/100ps
`include "rx_lane_settings.svh"

module tb_rx_lane import rx_lane_pkg::*; ();

    localparam int RUN_BLOCKS  = 300;
    // Up to 17 slips, each after a few random headers, then a clean run of good ones
    localparam int LOCK_BLOCKS = `RX_BLOCK_W * 8 + `RX_LOCK_GOOD + 2;
    localparam int LOCK_CYCLES = LOCK_BLOCKS * 9 / 8 + 8;
    localparam int TOTAL_WORDS = 3 * (LOCK_BLOCKS + RUN_BLOCKS + 4 * `RX_BAD_WINDOW);

    logic         i_clk = 1'b0;
    logic         i_rst = 1'b1;
    serdes_word_t i_data = '0;
    logic         o_lock;
    logic         o_valid;
    logic         o_ctrl;
    payload_t     o_data;

    integer                  seed = 32'h4d51d002;
    logic [31:0]             rnd;
    scr_state_t              tx_scr;
    bit                      tx_bits[$];           // Serial stream with the next bit at the front
    logic [`RX_PAYLOAD_W:0]  exp_q[$];             // {ctrl, payload} of every block sent
    serdes_word_t            word;
    int                      rst_left = 3;
    int                      bad_left = 0;
    int                      match_count = 0;
    int                      junk;
    bit                      synced = 1'b0;
    bit                      skip = 1'b0;
    bit                      prev_lock = 1'b0;

    rx_lane rx_lane_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_data  (i_data),
        .o_lock  (o_lock),
        .o_valid (o_valid),
        .o_ctrl  (o_ctrl),
        .o_data  (o_data)
    );

    always #5 i_clk = ~i_clk;

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_block(input logic exp_ctrl, input payload_t exp_data);
        if (o_data !== exp_data) begin
            $display("ERR o_data expected %h got %h", exp_data, o_data);
            fail_run();
        end
        if (o_ctrl !== exp_ctrl) begin
            $display("ERR o_ctrl expected %h got %h", exp_ctrl, o_ctrl);
            fail_run();
        end
    endtask

    task automatic check_lock(input logic exp_lock);
        if (o_lock !== exp_lock) begin
            $display("ERR o_lock expected %h got %h", exp_lock, o_lock);
            fail_run();
        end
    endtask

    // The transmitter sends the header first, then the payload through x^58 + x^39 + 1
    task automatic gen_block();
        payload_t  data;
        payload_t  scr;
        sync_hdr_t hdr;
        int        i;
        rnd  = $random(seed);
        data = rnd[`RX_PAYLOAD_W-1:0];
        hdr  = rnd[16] ? 2'b10 : 2'b01;
        if (bad_left > 0) begin
            hdr = 2'b00;
            bad_left--;
        end
        for (i = 0; i < `RX_PAYLOAD_W; i++) begin
            scr[i] = data[i] ^ tx_scr[`RX_SCR_LEN-1] ^ tx_scr[`RX_SCR_TAP-1];
            tx_scr = {tx_scr[`RX_SCR_LEN-2:0], scr[i]};
        end
        tx_bits.push_back(hdr[0]);
        tx_bits.push_back(hdr[1]);
        for (i = 0; i < `RX_PAYLOAD_W; i++) tx_bits.push_back(scr[i]);
        exp_q.push_back({hdr == 2'b10, data});
    endtask

    task automatic next_word(output serdes_word_t w);
        int i;
        while (tx_bits.size() < `RX_SERDES_W) gen_block();
        for (i = 0; i < `RX_SERDES_W; i++) w[i] = tx_bits.pop_front();
    endtask

    task automatic push_junk(input int n);
        int i;
        rnd = $random(seed);
        for (i = 0; i < n; i++) tx_bits.push_back(rnd[i]);
    endtask

    task automatic match_output();
        logic [`RX_PAYLOAD_W:0] exp;
        int                     idx;
        int                     i;
        if (synced) begin
            if (exp_q.size() == 0) begin
                $display("o_valid came with no sent block left to compare against");
                fail_run();
            end
            exp = exp_q.pop_front();
            check_block(exp[`RX_PAYLOAD_W], exp[`RX_PAYLOAD_W-1:0]);
        end else begin
            idx = -1;
            for (i = 0; i < exp_q.size(); i++) begin
                if (idx < 0 && exp_q[i] === {o_ctrl, o_data}) idx = i;
            end
            if (idx < 0) begin
                $display("First block after lock matches no block that was sent");
                fail_run();
            end
            for (i = 0; i <= idx; i++) exp = exp_q.pop_front();
            synced = 1'b1;
        end
        match_count++;
    endtask

    task automatic wait_lock(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (o_lock !== level) begin
            @(negedge i_clk);
            n++;
            if (n > max_cycles) begin
                $display("o_lock did not go to %0d within %0d cycles", level, max_cycles);
                fail_run();
            end
        end
    endtask

    // Lock has to hold while clean blocks come out in order
    task automatic wait_matches(input int n);
        int target;
        int cycles;
        target = match_count + n;
        cycles = 0;
        while (match_count < target) begin
            @(negedge i_clk);
            cycles++;
            check_lock(1'b1);
            if (cycles > 2 * n + 16) begin
                $display("Only %0d of %0d blocks came out in order", n - (target - match_count), n);
                fail_run();
            end
        end
    endtask

    // Reset release and the SERDES words share one process so the first word lines up
    always @(posedge i_clk) begin
        if (rst_left != 0) begin
            rst_left <= rst_left - 1;
        end else begin
            i_rst <= 1'b0;
            next_word(word);
            i_data <= word;
        end
    end

    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (o_valid && !prev_lock) begin  // o_valid follows lock by one register
                $display("o_valid was high without lock on the cycle before");
                fail_run();
            end
            if (!o_lock && !o_valid) begin
                synced = 1'b0;
                skip   = 1'b0;
            end
            if (o_valid && !skip) match_output();
            while (!synced && exp_q.size() > 32) exp_q.delete(0);
            prev_lock = o_lock;
        end
    end

    initial begin
        repeat (20 * TOTAL_WORDS) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles", 20 * TOTAL_WORDS);
        fail_run();
    end

    initial begin
        tx_scr = scr_state_t'({$random(seed), $random(seed)});
        rnd    = $random(seed);
        push_junk(int'(rnd[15:0]) % `RX_BLOCK_W);  // First block starts misaligned

        wait_lock(1'b1, LOCK_CYCLES);
        wait_matches(RUN_BLOCKS);

        // Twice the limit, so one loss window holds the limit whatever its phase
        bad_left = 2 * `RX_BAD_LIMIT;
        wait_lock(1'b0, 2 * `RX_BAD_WINDOW);
        wait_lock(1'b1, LOCK_CYCLES);
        wait_matches(RUN_BLOCKS);

        // A new bit offset mid stream leaves the blocks in flight as garbage until lock drops
        skip = 1'b1;
        rnd  = $random(seed);
        junk = 1 + int'(rnd[15:0]) % (`RX_BLOCK_W - 1);
        push_junk(junk);
        wait_lock(1'b0, 4 * `RX_BAD_WINDOW);
        wait_lock(1'b1, LOCK_CYCLES);
        wait_matches(RUN_BLOCKS);

        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog/block_aligner.sv */
`timescale 1ns/100ps
`include "rx_lane_settings.svh"

module block_aligner import rx_lane_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    block_if.aligner  blk,
    output logic      o_lock,
    output logic      o_blk_valid,
    output sync_hdr_t o_blk_header,
    output payload_t  o_blk_payload
);

    localparam int GOOD_W = $clog2(`RX_LOCK_GOOD);
    localparam int WIN_W  = $clog2(`RX_BAD_WINDOW);
    localparam int BAD_W  = $clog2(`RX_BAD_LIMIT + 1);

    align_state_t      state;
    logic [GOOD_W-1:0] good_cnt;
    logic [WIN_W-1:0]  win_cnt;
    logic [BAD_W-1:0]  bad_cnt;
    logic              hdr_check;
    logic              hdr_ok;

    // A block shown during the slip cycle was framed before the slip took effect
    assign hdr_check = blk.blk_valid && !blk.slip;
    assign hdr_ok    = ^blk.blk_header;  // Only 01 and 10 are legal

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= ALIGN_HUNT;
            good_cnt <= '0;
            win_cnt  <= '0;
            bad_cnt  <= '0;
            blk.slip <= 1'b0;
        end else begin
            blk.slip <= 1'b0;
            case (state)
                ALIGN_HUNT: begin
                    win_cnt <= '0;
                    bad_cnt <= '0;
                    if (hdr_check) begin
                        if (!hdr_ok) begin
                            good_cnt <= '0;
                            blk.slip <= 1'b1;  // Try the next bit position
                        end else if (good_cnt == GOOD_W'(`RX_LOCK_GOOD - 1)) begin
                            good_cnt <= '0;
                            state    <= ALIGN_LOCKED;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                        end
                    end
                end
                ALIGN_LOCKED: begin
                    if (blk.blk_valid) begin
                        if (!hdr_ok && bad_cnt == BAD_W'(`RX_BAD_LIMIT - 1)) begin
                            state   <= ALIGN_HUNT;
                            win_cnt <= '0;
                            bad_cnt <= '0;
                        end else if (win_cnt == WIN_W'(`RX_BAD_WINDOW - 1)) begin
                            // Window closed without reaching the limit
                            win_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                            if (!hdr_ok) begin
                                bad_cnt <= bad_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: state <= ALIGN_HUNT;
            endcase
        end
    end

    assign o_lock = (state == ALIGN_LOCKED);

    // Blocks flow on even while hunting so the descrambler history stays filled
    assign o_blk_valid   = blk.blk_valid;
    assign o_blk_header  = blk.blk_header;
    assign o_blk_payload = blk.blk_payload;

    a_no_slip_locked: assert property (
        @(posedge i_clk) disable iff (i_rst)
        blk.slip |-> state == ALIGN_HUNT
    );

    a_slip_single: assert property (
        @(posedge i_clk) disable iff (i_rst)
        blk.slip |=> !blk.slip
    );

endmodule

/* verilog/block_if.sv */
`timescale 1ns/100ps

interface block_if import rx_lane_pkg::*; ();

    logic      blk_valid;
    sync_hdr_t blk_header;
    payload_t  blk_payload;
    logic      slip;          // One-cycle pulse that drops the oldest buffered bit

    modport gearbox (
        output blk_valid, blk_header, blk_payload,
        input  slip
    );

    modport aligner (
        input  blk_valid, blk_header, blk_payload,
        output slip
    );

endinterface

/* verilog/descrambler.sv */
`timescale 1ns/100ps
`include "rx_lane_settings.svh"

module descrambler import rx_lane_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_lock,
    input  logic      i_blk_valid,
    input  sync_hdr_t i_blk_header,
    input  payload_t  i_blk_payload,
    output logic      o_valid,
    output logic      o_ctrl,
    output payload_t  o_data
);

    scr_state_t history;
    scr_state_t next_history;
    payload_t   plain;

    // Bit 0 of the payload is the first bit sent
    always_comb begin
        next_history = history;
        for (int i = 0; i < `RX_PAYLOAD_W; i++) begin
            plain[i] = i_blk_payload[i] ^ next_history[`RX_SCR_LEN-1]
                     ^ next_history[`RX_SCR_TAP-1];
            next_history = {next_history[`RX_SCR_LEN-2:0], i_blk_payload[i]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_blk_valid && i_lock;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_blk_valid) begin
            history <= next_history;  // Holds scrambled bits so the state resyncs itself
            o_data  <= plain;
            o_ctrl  <= (i_blk_header == 2'b10);
        end
    end

endmodule

/* verilog/rx_gearbox.sv */
`timescale 1ns/100ps
`include "rx_lane_settings.svh"

module rx_gearbox import rx_lane_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  serdes_word_t i_data,
    block_if.gearbox     blk
);

    localparam int BUF_W  = `RX_BLOCK_W + `RX_SERDES_W;
    localparam int FILL_W = $clog2(BUF_W + 1);

    logic [BUF_W-1:0]  shift_buf;  // Oldest bit at position 0
    logic [FILL_W-1:0] fill;
    logic [BUF_W-1:0]  slip_buf;
    logic [FILL_W-1:0] slip_fill;
    logic [BUF_W-1:0]  rest_buf;
    logic [FILL_W-1:0] rest_fill;
    logic              emit;
    logic [7:0]        valid_hist;

    // Slip first, then take a block off the bottom, then append the new word on top
    always_comb begin
        slip_buf  = shift_buf;
        slip_fill = fill;
        if (blk.slip && fill != '0) begin
            slip_buf  = shift_buf >> 1;
            slip_fill = fill - 1'b1;
        end
        emit = slip_fill >= FILL_W'(`RX_BLOCK_W);
        if (emit) begin
            rest_buf  = slip_buf >> `RX_BLOCK_W;
            rest_fill = slip_fill - FILL_W'(`RX_BLOCK_W);
        end else begin
            rest_buf  = slip_buf;
            rest_fill = slip_fill;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            shift_buf     <= '0;
            fill          <= '0;
            blk.blk_valid <= 1'b0;
        end else begin
            // Bits above the fill level are always zero, so the new word can be ORed in
            shift_buf     <= rest_buf | (BUF_W'(i_data) << rest_fill);
            fill          <= rest_fill + FILL_W'(`RX_SERDES_W);
            blk.blk_valid <= emit;
        end
    end

    // Header goes first on the wire, payload follows
    always_ff @(posedge i_clk) begin
        if (emit) begin
            blk.blk_header  <= slip_buf[`RX_HDR_W-1:0];
            blk.blk_payload <= slip_buf[`RX_BLOCK_W-1:`RX_HDR_W];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[6:0], blk.blk_valid};
        end
    end

    a_fill_max: assert property (
        @(posedge i_clk) disable iff (i_rst)
        fill <= FILL_W'(BUF_W)
    );

    // 16 bits in per cycle cannot sustain nine 18-bit blocks in a row
    a_block_rate: assert property (
        @(posedge i_clk) disable iff (i_rst)
        blk.blk_valid |-> !(&valid_hist)
    );

endmodule

/* verilog/rx_lane.sv */
`timescale 1ns/100ps

module rx_lane import rx_lane_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  serdes_word_t i_data,
    output logic         o_lock,
    output logic         o_valid,
    output logic         o_ctrl,
    output payload_t     o_data
);

    logic      al_blk_valid;
    sync_hdr_t al_blk_header;
    payload_t  al_blk_payload;

    // Blocks run from gearbox to aligner and slip runs back the other way
    block_if blk_bus ();

    rx_gearbox rx_gearbox_inst (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_data (i_data),
        .blk    (blk_bus.gearbox)
    );

    block_aligner block_aligner_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .blk           (blk_bus.aligner),
        .o_lock        (o_lock),
        .o_blk_valid   (al_blk_valid),
        .o_blk_header  (al_blk_header),
        .o_blk_payload (al_blk_payload)
    );

    descrambler descrambler_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_lock        (o_lock),
        .i_blk_valid   (al_blk_valid),
        .i_blk_header  (al_blk_header),
        .i_blk_payload (al_blk_payload),
        .o_valid       (o_valid),
        .o_ctrl        (o_ctrl),
        .o_data        (o_data)
    );

endmodule

/* verilog/rx_lane_pkg.sv */
`include "rx_lane_settings.svh"

package rx_lane_pkg;

    typedef logic [`RX_SERDES_W-1:0]  serdes_word_t;
    typedef logic [`RX_HDR_W-1:0]     sync_hdr_t;   // 2'b01 data, 2'b10 control
    typedef logic [`RX_PAYLOAD_W-1:0] payload_t;

    // Bit 0 holds the most recently received scrambled bit
    typedef logic [`RX_SCR_LEN-1:0]   scr_state_t;

    typedef enum logic {
        ALIGN_HUNT,
        ALIGN_LOCKED
    } align_state_t;

endpackage

/* verilog/rx_lane_settings.svh */
`ifndef RX_LANE_SETTINGS_SVH
`define RX_LANE_SETTINGS_SVH

// Bit 0 of every word is the earliest bit on the wire
`define RX_SERDES_W   16
`define RX_HDR_W      2
`define RX_PAYLOAD_W  16
`define RX_BLOCK_W    18

// Block aligner thresholds
`define RX_LOCK_GOOD  64
`define RX_BAD_WINDOW 64
`define RX_BAD_LIMIT  16

// Scrambler polynomial x^58 + x^39 + 1
`define RX_SCR_LEN    58
`define RX_SCR_TAP    39

`endif
